// File: Bender.yml
package:
  name: if_stage

sources:
  # Fetch stage RTL in compile order
  - include_dirs:
      - source
    files:
      - source/if_pkg.sv
      - source/if_pc_mux.sv
      - source/if_prefetch_ctrl.sv
      - source/if_fetch_fifo.sv
      - source/if_id_pipe.sv
      - source/if_stage.sv

  # Bus model and testbench top
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_instr_mem.sv
      - tests/tb_if_stage.sv

// File: all.f
+incdir+source
source/if_pkg.sv
source/if_pc_mux.sv
source/if_prefetch_ctrl.sv
source/if_fetch_fifo.sv
source/if_id_pipe.sv
source/if_stage.sv
tests/tb_instr_mem.sv
tests/tb_if_stage.sv

// File: source/if_defines.svh
`ifndef IF_DEFINES_SVH
`define IF_DEFINES_SVH

// Shared widths and sizes for the instruction fetch stage

// Address and instruction data width
`define IF_ADDR_W 32

// Trap vector layout
// Base field of mtvec sits above the vector offset
`define IF_MTVEC_W 25
// Interrupt index placed between base and word offset
`define IF_IRQ_ID_W 5

// Buffering
`define IF_FIFO_DEPTH 2
// Bus transactions allowed in flight
`define IF_MAX_OUTSTANDING 2
// Holds 0 to 2 for occupancy and outstanding counts
`define IF_CNT_W 2

// PC held in the IF/ID register out of reset
`define IF_RESET_PC 32'h0000_0000

`endif

// File: source/if_fetch_fifo.sv
`default_nettype none

`include "if_defines.svh"

module if_fetch_fifo (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush_i,
  input  logic                  push_i,
  input  logic [`IF_ADDR_W-1:0] push_data_i,
  input  logic                  push_err_i,
  input  logic [`IF_ADDR_W-1:0] push_addr_i,
  input  logic                  halt_i,
  input  logic                  kill_i,
  input  logic                  ready_i,
  output logic [`IF_CNT_W-1:0]  cnt_o,
  output logic                  valid_o,
  output logic [`IF_ADDR_W-1:0] instr_o,
  output logic [`IF_ADDR_W-1:0] pc_o,
  output logic                  err_o,
  output logic [`IF_ADDR_W-1:0] pc_if_o
);

  localparam int PTR_W = $clog2(`IF_FIFO_DEPTH);

  logic [`IF_ADDR_W-1:0] data_mem [`IF_FIFO_DEPTH];
  logic [`IF_ADDR_W-1:0] addr_mem [`IF_FIFO_DEPTH];
  logic                  err_mem  [`IF_FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [`IF_CNT_W-1:0]  cnt_q;
  logic                  empty;
  logic                  full;
  logic                  pop;

  assign empty = (cnt_q == '0);
  assign full  = (cnt_q == `IF_FIFO_DEPTH);
  assign cnt_o = cnt_q;

  // Head is offered only while IF is neither halted nor killed
  assign valid_o = !empty && !halt_i && !kill_i;
  // A kill drops the head without handing it to ID
  assign pop     = (valid_o && ready_i) || (kill_i && !empty);

  assign instr_o = data_mem[rd_ptr_q];
  assign err_o   = err_mem[rd_ptr_q];
  assign pc_o    = addr_mem[rd_ptr_q];
  assign pc_if_o = addr_mem[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      // Redirect empties the buffer
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_i && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!push_i && pop) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      data_mem[wr_ptr_q] <= push_data_i;
      err_mem[wr_ptr_q]  <= push_err_i;
      addr_mem[wr_ptr_q] <= push_addr_i;
    end
  end

  // Prefetcher reserves space before it issues a request
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    (push_i && full) |-> pop);

endmodule

`default_nettype wire

// File: source/if_id_pipe.sv
`default_nettype none

`include "if_defines.svh"

module if_id_pipe (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  if_valid_i,
  input  logic [`IF_ADDR_W-1:0] instr_i,
  input  logic [`IF_ADDR_W-1:0] pc_i,
  input  logic                  err_i,
  input  logic                  id_ready_i,
  output logic                  if_ready_o,
  output logic                  id_valid_o,
  output logic [`IF_ADDR_W-1:0] id_instr_o,
  output logic [`IF_ADDR_W-1:0] id_pc_o,
  output logic                  id_abort_o
);

  ////////////////////
  // IF/ID register
  ////////////////////

  // Register takes a new value whenever ID can accept one
  assign if_ready_o = id_ready_i;

  // Valid, PC and abort flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o <= 1'b0;
      id_pc_o    <= `IF_RESET_PC;
      id_abort_o <= 1'b0;
    end else if (id_ready_i) begin
      // Bubble when nothing is offered
      id_valid_o <= if_valid_i;
      if (if_valid_i) begin
        id_pc_o    <= pc_i;
        // Bus error turns into an abort for ID
        id_abort_o <= err_i;
      end
    end
  end

  // Instruction word
  always_ff @(posedge clk) begin
    if (id_ready_i && if_valid_i) begin
      id_instr_o <= instr_i;
    end
  end

endmodule

`default_nettype wire

// File: source/if_pc_mux.sv
`default_nettype none

`include "if_defines.svh"

module if_pc_mux import if_pkg::*; (
  input  pc_mux_e                  pc_mux_i,
  input  logic                     pc_set_i,
  input  logic [`IF_ADDR_W-1:0]    boot_addr_i,
  input  logic [`IF_ADDR_W-1:0]    jump_target_i,
  input  logic [`IF_ADDR_W-1:0]    branch_target_i,
  input  logic [`IF_ADDR_W-1:0]    mepc_i,
  input  logic [`IF_MTVEC_W-1:0]   mtvec_addr_i,
  input  logic [`IF_IRQ_ID_W-1:0]  irq_id_i,
  output logic [`IF_ADDR_W-1:0]    branch_addr_o,
  output logic                     csr_mtvec_init_o
);

  ////////////////////
  // Target selection
  ////////////////////

  always_comb begin
    // Boot address unless another source is selected
    branch_addr_o = {boot_addr_i[`IF_ADDR_W-1:2], 2'b00};

    unique case (pc_mux_i)
      PC_BOOT:     branch_addr_o = {boot_addr_i[`IF_ADDR_W-1:2], 2'b00};
      PC_JUMP:     branch_addr_o = {jump_target_i[`IF_ADDR_W-1:2], 2'b00};
      PC_BRANCH:   branch_addr_o = {branch_target_i[`IF_ADDR_W-1:2], 2'b00};
      // Return to the interrupted instruction
      PC_MRET:     branch_addr_o = {mepc_i[`IF_ADDR_W-1:2], 2'b00};
      // Every exception shares the mtvec base
      PC_TRAP_EXC: branch_addr_o = {mtvec_addr_i, 7'h00};
      // Interrupts are vectored by their index
      PC_TRAP_IRQ: branch_addr_o = {mtvec_addr_i, irq_id_i, 2'b00};
      default:     ;
    endcase
  end

  // CSR file loads mtvec from the boot address on the boot redirect
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  // Controller must present a defined source with every redirect
  always_comb begin
    if (pc_set_i) begin
      a_pc_mux_known : assert final (!$isunknown(pc_mux_i) && (pc_mux_i inside
        {PC_BOOT, PC_JUMP, PC_BRANCH, PC_MRET, PC_TRAP_EXC, PC_TRAP_IRQ}))
        else $error("pc_set with undefined pc_mux value %0d", pc_mux_i);
    end
  end

endmodule

`default_nettype wire

// File: source/if_pkg.sv
`default_nettype none

package if_pkg;

  ////////////////////
  // PC source select
  ////////////////////

  // Driven by the controller together with pc_set
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

  ////////////////////
  // Prefetch state
  ////////////////////

  // Idle until the first redirect gives a valid fetch address
  typedef enum logic {
    FETCH_IDLE = 1'b0,
    FETCH_RUN  = 1'b1
  } fetch_state_e;

endpackage

`default_nettype wire

// File: source/if_prefetch_ctrl.sv
`default_nettype none

`include "if_defines.svh"

module if_prefetch_ctrl import if_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pc_set_i,
  input  logic [`IF_ADDR_W-1:0] branch_addr_i,
  input  logic [`IF_CNT_W-1:0]  fifo_cnt_i,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [`IF_ADDR_W-1:0] instr_rdata_i,
  input  logic                  instr_err_i,
  output logic                  instr_req_o,
  output logic [`IF_ADDR_W-1:0] instr_addr_o,
  output logic                  push_o,
  output logic [`IF_ADDR_W-1:0] push_data_o,
  output logic                  push_err_o,
  output logic [`IF_ADDR_W-1:0] push_addr_o,
  output logic                  busy_o
);

  localparam int PTR_W = $clog2(`IF_MAX_OUTSTANDING);

  fetch_state_e          state_q;
  logic [`IF_ADDR_W-1:0] addr_q;
  // Addresses of issued requests, oldest at the read pointer
  logic [`IF_ADDR_W-1:0] aq_mem [`IF_MAX_OUTSTANDING];
  logic [PTR_W-1:0]      aq_wr_q;
  logic [PTR_W-1:0]      aq_rd_q;
  logic [`IF_CNT_W-1:0]  out_cnt_q;
  logic [`IF_CNT_W-1:0]  discard_q;
  logic [`IF_CNT_W-1:0]  live_cnt;
  logic [`IF_CNT_W:0]    slots_used;
  logic                  granted;
  logic                  discard_rsp;

  ////////////////////
  // Request issue
  ////////////////////

  // Outstanding requests whose responses will still reach the FIFO
  assign live_cnt   = out_cnt_q - discard_q;
  assign slots_used = {1'b0, live_cnt} + {1'b0, fifo_cnt_i};

  // No request in a redirect cycle since the address is about to change
  assign instr_req_o = (state_q == FETCH_RUN) && !pc_set_i &&
                       (out_cnt_q < `IF_MAX_OUTSTANDING) &&
                       (slots_used < `IF_FIFO_DEPTH);
  assign instr_addr_o = addr_q;
  assign granted      = instr_req_o && instr_gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FETCH_IDLE;
      addr_q  <= '0;
    end else if (pc_set_i) begin
      state_q <= FETCH_RUN;
      addr_q  <= branch_addr_i;
    end else if (granted) begin
      // Sequential word fetch
      addr_q <= addr_q + 32'd4;
    end
  end

  ////////////////////
  // Response handling
  ////////////////////

  // Responses to requests issued before a redirect are dropped
  assign discard_rsp = instr_rvalid_i && (discard_q != '0);
  // FIFO is flushed in a redirect cycle so nothing is pushed then
  assign push_o      = instr_rvalid_i && (discard_q == '0) && !pc_set_i;
  assign push_data_o = instr_rdata_i;
  assign push_err_o  = instr_err_i;
  assign push_addr_o = aq_mem[aq_rd_q];
  assign busy_o      = (out_cnt_q != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q <= '0;
      discard_q <= '0;
      aq_wr_q   <= '0;
      aq_rd_q   <= '0;
    end else begin
      out_cnt_q <= out_cnt_q + {{(`IF_CNT_W-1){1'b0}}, granted}
                             - {{(`IF_CNT_W-1){1'b0}}, instr_rvalid_i};
      if (pc_set_i) begin
        // Everything still in flight after this cycle is stale
        discard_q <= out_cnt_q - {{(`IF_CNT_W-1){1'b0}}, instr_rvalid_i};
      end else if (discard_rsp) begin
        discard_q <= discard_q - 1'b1;
      end
      // Tag queue advances on every grant and response alike
      if (granted) begin
        aq_wr_q <= aq_wr_q + 1'b1;
      end
      if (instr_rvalid_i) begin
        aq_rd_q <= aq_rd_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (granted) begin
      aq_mem[aq_wr_q] <= addr_q;
    end
  end

  // FIFO space reservation must also bound bus occupancy
  a_out_cnt_max : assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt_q <= `IF_MAX_OUTSTANDING);

  // Bus must not answer a request that was never granted
  a_rvalid_pending : assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (out_cnt_q != '0));

endmodule

`default_nettype wire

// File: source/if_stage.sv
`default_nettype none

`include "if_defines.svh"

module if_stage import if_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,

  // Controller
  input  logic                    pc_set_i,
  input  pc_mux_e                 pc_mux_i,
  input  logic                    kill_if_i,
  input  logic                    halt_if_i,
  input  logic [`IF_IRQ_ID_W-1:0] irq_id_i,
  input  logic [`IF_ADDR_W-1:0]   boot_addr_i,
  input  logic [`IF_ADDR_W-1:0]   jump_target_i,
  input  logic [`IF_ADDR_W-1:0]   branch_target_i,
  input  logic [`IF_ADDR_W-1:0]   mepc_i,
  input  logic [`IF_MTVEC_W-1:0]  mtvec_addr_i,

  // Instruction bus
  output logic                    instr_req_o,
  output logic [`IF_ADDR_W-1:0]   instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  logic [`IF_ADDR_W-1:0]   instr_rdata_i,
  input  logic                    instr_err_i,

  // ID stage
  input  logic                    id_ready_i,
  output logic                    id_valid_o,
  output logic [`IF_ADDR_W-1:0]   id_instr_o,
  output logic [`IF_ADDR_W-1:0]   id_pc_o,
  output logic                    id_abort_o,

  // Status
  output logic [`IF_ADDR_W-1:0]   pc_if_o,
  output logic                    if_busy_o,
  output logic                    csr_mtvec_init_o
);

  logic [`IF_ADDR_W-1:0] branch_addr;
  logic [`IF_CNT_W-1:0]  fifo_cnt;
  logic                  push;
  logic [`IF_ADDR_W-1:0] push_data;
  logic                  push_err;
  logic [`IF_ADDR_W-1:0] push_addr;
  logic                  if_valid;
  logic                  if_ready;
  logic [`IF_ADDR_W-1:0] fifo_instr;
  logic [`IF_ADDR_W-1:0] fifo_pc;
  logic                  fifo_err;

  ////////////////////
  // Next PC
  ////////////////////

  if_pc_mux i_pc_mux (
    .pc_mux_i         (pc_mux_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  ////////////////////
  // Prefetch
  ////////////////////

  if_prefetch_ctrl i_prefetch_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .branch_addr_i  (branch_addr),
    .fifo_cnt_i     (fifo_cnt),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .push_o         (push),
    .push_data_o    (push_data),
    .push_err_o     (push_err),
    .push_addr_o    (push_addr),
    .busy_o         (if_busy_o)
  );

  // Redirect doubles as the FIFO flush
  if_fetch_fifo i_fetch_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (pc_set_i),
    .push_i      (push),
    .push_data_i (push_data),
    .push_err_i  (push_err),
    .push_addr_i (push_addr),
    .halt_i      (halt_if_i),
    .kill_i      (kill_if_i),
    .ready_i     (if_ready),
    .cnt_o       (fifo_cnt),
    .valid_o     (if_valid),
    .instr_o     (fifo_instr),
    .pc_o        (fifo_pc),
    .err_o       (fifo_err),
    .pc_if_o     (pc_if_o)
  );

  ////////////////////
  // Handoff to ID
  ////////////////////

  if_id_pipe i_if_id_pipe (
    .clk        (clk),
    .rst_n      (rst_n),
    .if_valid_i (if_valid),
    .instr_i    (fifo_instr),
    .pc_i       (fifo_pc),
    .err_i      (fifo_err),
    .id_ready_i (id_ready_i),
    .if_ready_o (if_ready),
    .id_valid_o (id_valid_o),
    .id_instr_o (id_instr_o),
    .id_pc_o    (id_pc_o),
    .id_abort_o (id_abort_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_if_stage.sv
`default_nettype none

`include "if_defines.svh"

module tb_if_stage import if_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED           = 32'hc302;
  localparam logic [31:0] DATA_KEY       = 32'h5a3c_96e1;
  // Bus error region, 16 words
  localparam logic [31:0] ERR_LO         = 32'h0000_3000;
  localparam logic [31:0] ERR_HI         = 32'h0000_3040;
  localparam logic [31:0] BOOT_ADDR      = 32'h0000_1006;
  localparam int          TIMEOUT_CYCLES = 20000;

  logic                    clk;
  logic                    rst_n;
  logic                    pc_set_i;
  pc_mux_e                 pc_mux_i;
  logic                    kill_if_i;
  logic                    halt_if_i;
  logic [`IF_IRQ_ID_W-1:0] irq_id_i;
  logic [`IF_ADDR_W-1:0]   boot_addr_i;
  logic [`IF_ADDR_W-1:0]   jump_target_i;
  logic [`IF_ADDR_W-1:0]   branch_target_i;
  logic [`IF_ADDR_W-1:0]   mepc_i;
  logic [`IF_MTVEC_W-1:0]  mtvec_addr_i;
  logic                    instr_req_o;
  logic [`IF_ADDR_W-1:0]   instr_addr_o;
  logic                    instr_gnt_i;
  logic                    instr_rvalid_i;
  logic [`IF_ADDR_W-1:0]   instr_rdata_i;
  logic                    instr_err_i;
  logic                    id_ready_i;
  logic                    id_valid_o;
  logic [`IF_ADDR_W-1:0]   id_instr_o;
  logic [`IF_ADDR_W-1:0]   id_pc_o;
  logic                    id_abort_o;
  logic [`IF_ADDR_W-1:0]   pc_if_o;
  logic                    if_busy_o;
  logic                    csr_mtvec_init_o;

  // Stimulus side
  logic [31:0] rand_q;
  logic [1:0]  ready_bias;
  string       test_name;
  int          cycles = 0;
  // High in the cycle a boot redirect is presented
  logic        exp_mtvec_init;
  // Shared with stimulus, written by the checker with NBAs
  int          n_seen;
  int          n_abort;
  int          first_cnt;
  // Checker only
  logic [31:0] exp_pc;
  logic        boot_seen;
  logic        first_pending;
  pc_mux_e     cur_src;
  logic        hold_prev;
  logic        halt_prev;
  logic [31:0] held_pc;
  logic [31:0] held_instr;
  logic        held_abort;
  logic        ready_prev;
  logic [31:0] pc_if_prev;
  int          bus_pending;
  // Targets of every source at the last redirect
  logic [31:0] tgt_of [6];

  if_stage i_dut (.*);

  tb_instr_mem #(
    .SEED     (SEED),
    .DATA_KEY (DATA_KEY),
    .ERR_LO   (ERR_LO),
    .ERR_HI   (ERR_HI)
  ) i_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i),
    .err_o    (instr_err_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [31:0] next_rand();
    rand_q = rand_q * 32'd1664525 + 32'd1013904223;
    return rand_q;
  endfunction

  // Fetch target of a redirect
  function automatic logic [`IF_ADDR_W-1:0] ref_target(
    input pc_mux_e src, input logic [31:0] boot, input logic [31:0] jump,
    input logic [31:0] branch, input logic [31:0] mepc,
    input logic [`IF_MTVEC_W-1:0] mtvec, input logic [`IF_IRQ_ID_W-1:0] irq);
    case (src)
      PC_BOOT:     return {boot[31:2], 2'b00};
      PC_JUMP:     return {jump[31:2], 2'b00};
      PC_BRANCH:   return {branch[31:2], 2'b00};
      PC_MRET:     return {mepc[31:2], 2'b00};
      PC_TRAP_EXC: return {mtvec, 7'h00};
      PC_TRAP_IRQ: return {mtvec, irq, 2'b00};
      default:     return 'x;
    endcase
  endfunction

  function automatic logic [31:0] ref_instr(input logic [31:0] pc);
    return pc ^ DATA_KEY;
  endfunction

  function automatic logic ref_err(input logic [31:0] pc);
    return (pc >= ERR_LO) && (pc < ERR_HI);
  endfunction

  // Redirect source whose target is this PC, the intended one if it fits
  function automatic pc_mux_e source_of_pc(input logic [31:0] pc, input pc_mux_e want);
    pc_mux_e src;
    src = pc_mux_e'(3'd7);
    for (int s = 0; s < 6; s++) begin
      if (tgt_of[s] == pc) begin
        src = pc_mux_e'(s);
      end
    end
    if (tgt_of[want] == pc) begin
      src = want;
    end
    return src;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input string what, input logic [`IF_ADDR_W-1:0] exp,
                            input logic [`IF_ADDR_W-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch in test %s: %s expected %h actual %h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch in test %s: %s expected %b actual %b",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_src(input string what, input pc_mux_e exp, input pc_mux_e act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch in test %s: %s expected %s actual %s",
                          test_name, what, exp.name(), act.name()));
    end
  endtask

  ////////////////////
  // Checker
  ////////////////////

  always @(posedge clk) begin
    // mtvec init only with a boot redirect, reset included
    check_bit("csr_mtvec_init_o", exp_mtvec_init, csr_mtvec_init_o);
    if (!rst_n) begin
      n_seen        <= 0;
      n_abort       <= 0;
      first_cnt     <= 0;
      boot_seen     = 1'b0;
      first_pending = 1'b0;
      hold_prev     = 1'b0;
      halt_prev     = 1'b0;
      ready_prev    = 1'b0;
      bus_pending   = 0;
    end else begin
      // Busy follows the transactions seen on the bus
      check_bit("if_busy_o", bus_pending != 0, if_busy_o);
      bus_pending = bus_pending + int'(instr_req_o && instr_gnt_i)
                                - int'(instr_rvalid_i);
      // ID outputs stay put through a stall
      if (hold_prev) begin
        check_bit("id_valid_o held", 1'b1, id_valid_o);
        check_word("id_pc_o held", held_pc, id_pc_o);
        check_word("id_instr_o held", held_instr, id_instr_o);
        check_bit("id_abort_o held", held_abort, id_abort_o);
      end
      // Halted IF hands nothing to ID
      if (halt_prev) begin
        check_bit("id_valid_o after halt", 1'b0, id_valid_o);
      end
      // Word now in the ID register left the FIFO head as pc_if_o
      if (ready_prev && id_valid_o) begin
        check_word("pc_if_o", exp_pc, pc_if_prev);
      end
      // Handshake belongs to the stream before any redirect in this cycle
      if (id_valid_o && id_ready_i) begin
        if (!boot_seen) begin
          abort_run("An instruction reached ID before the first redirect");
        end else begin
          if (first_pending) begin
            // First word of a stream must come from the redirect target
            check_src("source of first instruction", cur_src,
                      source_of_pc(id_pc_o, cur_src));
            first_cnt     <= first_cnt + 1;
            first_pending = 1'b0;
          end
          check_word("id_pc_o", exp_pc, id_pc_o);
          check_word("id_instr_o", ref_instr(exp_pc), id_instr_o);
          check_bit("id_abort_o", ref_err(exp_pc), id_abort_o);
          n_seen  <= n_seen + 1;
          n_abort <= n_abort + int'(id_abort_o);
          exp_pc = exp_pc + 32'd4;
        end
      end
      // New stream starts at the redirect target
      if (pc_set_i) begin
        for (int s = 0; s < 6; s++) begin
          tgt_of[s] = ref_target(pc_mux_e'(s), boot_addr_i, jump_target_i,
                                 branch_target_i, mepc_i, mtvec_addr_i, irq_id_i);
        end
        exp_pc        = tgt_of[pc_mux_i];
        cur_src       = pc_mux_i;
        first_pending = 1'b1;
        boot_seen     = 1'b1;
      end
      hold_prev  = id_valid_o && !id_ready_i;
      held_pc    = id_pc_o;
      held_instr = id_instr_o;
      held_abort = id_abort_o;
      halt_prev  = halt_if_i && id_ready_i;
      ready_prev = id_ready_i;
      pc_if_prev = pc_if_o;
    end
  end

  // Limit about ten times the expected run length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: tests not finished after %0d cycles", cycles));
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // One cycle of normal operation with random ID back-pressure
  task automatic step();
    logic [31:0] r;
    @(posedge clk);
    r = next_rand();
    pc_set_i       <= 1'b0;
    kill_if_i      <= 1'b0;
    exp_mtvec_init <= 1'b0;
    id_ready_i     <= (r[13:12] >= ready_bias);
  endtask

  task automatic wait_instrs(input int n);
    int start;
    start = n_seen;
    while (n_seen - start < n) begin
      step();
    end
  endtask

  // Redirect with kill, then wait for the first word of the new stream
  task automatic redirect(input pc_mux_e src, input logic [31:0] tgt);
    logic [31:0] r;
    int          start;
    @(posedge clk);
    r = next_rand();
    jump_target_i <= (src == PC_JUMP) ? tgt : r;
    r = next_rand();
    branch_target_i <= (src == PC_BRANCH) ? tgt : r;
    r = next_rand();
    mepc_i <= (src == PC_MRET) ? tgt : r;
    if (src == PC_BOOT) begin
      boot_addr_i <= tgt;
    end
    r = next_rand();
    mtvec_addr_i   <= r[31:7];
    irq_id_i       <= r[6:2];
    pc_mux_i       <= src;
    pc_set_i       <= 1'b1;
    exp_mtvec_init <= (src == PC_BOOT);
    kill_if_i      <= 1'b1;
    // ID register takes the bubble so no old word survives the redirect
    id_ready_i     <= 1'b1;
    start = first_cnt;
    step();
    while (first_cnt == start) begin
      step();
    end
  endtask

  initial begin
    logic [31:0] r;
    rst_n           = 1'b0;
    pc_set_i        = 1'b0;
    pc_mux_i        = PC_BOOT;
    kill_if_i       = 1'b0;
    halt_if_i       = 1'b0;
    irq_id_i        = '0;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    mtvec_addr_i    = '0;
    id_ready_i      = 1'b0;
    exp_mtvec_init  = 1'b0;
    rand_q          = SEED;
    ready_bias      = 2'd1;
    test_name       = "reset";
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    step();
    check_bit("instr_req_o after reset", 1'b0, instr_req_o);
    check_bit("id_valid_o after reset", 1'b0, id_valid_o);
    check_bit("if_busy_o after reset", 1'b0, if_busy_o);

    test_name <= "boot";
    redirect(PC_BOOT, BOOT_ADDR);
    wait_instrs(40);

    // Random targets, some unaligned, some inside the error region
    test_name <= "redirect";
    for (int i = 0; i < 16; i++) begin
      r = next_rand();
      redirect(pc_mux_e'(r[7:0] % 3 + 1), {18'h0, r[29:16]});
      wait_instrs(int'(r[10:8]) % 6);
    end

    test_name <= "trap";
    repeat (4) begin
      redirect(PC_TRAP_EXC, '0);
      wait_instrs(4);
      redirect(PC_TRAP_IRQ, '0);
      wait_instrs(4);
    end

    // Heavier back-pressure, then a halt window
    test_name <= "stall";
    ready_bias = 2'd2;
    redirect(PC_JUMP, 32'h0000_0800);
    wait_instrs(10);
    halt_if_i <= 1'b1;
    repeat (12) step();
    halt_if_i <= 1'b0;
    wait_instrs(20);
    ready_bias = 2'd1;

    // Stream runs through the whole error region
    test_name <= "bus_error";
    redirect(PC_BRANCH, ERR_LO - 32'd16);
    wait_instrs(24);

    if ((n_abort == 0) || (n_seen < 100)) begin
      abort_run("Too few instructions reached ID or no bus error was delivered");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_instr_mem.sv
`default_nettype none

module tb_instr_mem #(
  parameter logic [31:0] SEED     = 32'h1,
  parameter logic [31:0] DATA_KEY = 32'h0,
  parameter logic [31:0] ERR_LO   = 32'h0,
  parameter logic [31:0] ERR_HI   = 32'h0
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] lcg_q;
  // Accepted requests in bus order, with the cycle each may answer
  logic [31:0] pend_addr[$];
  int          pend_due[$];
  int          cycle;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    lcg_q    = SEED;
    cycle    = 0;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      lcg_q    <= SEED;
      cycle = 0;
      pend_addr.delete();
      pend_due.delete();
    end else begin
      cycle = cycle + 1;
      rvalid_o <= 1'b0;
      // Oldest request answers once its delay has run out
      if ((pend_addr.size() != 0) && (pend_due[0] <= cycle)) begin
        rvalid_o <= 1'b1;
        rdata_o  <= pend_addr[0] ^ DATA_KEY;
        err_o    <= (pend_addr[0] >= ERR_LO) && (pend_addr[0] < ERR_HI);
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      // Handshake seen on the values before this edge
      if (req_i && gnt_o) begin
        pend_addr.push_back(addr_i);
        pend_due.push_back(cycle + int'(lcg_q[17:16]));
      end
      // Grant about three cycles in four
      gnt_o <= (lcg_q[29:28] != 2'b00);
      lcg_q <= lcg_step(lcg_q);
    end
  end

endmodule

`default_nettype wire
